//--- compile.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/regFile.sv
verilog/stallDetector.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/procTop.sv
bench/procBus_properties.sv
bench/procTb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -sv -f compile.f --top-module procTb -Mdir obj_dir -o simv

run: build
	./obj_dir/simv | tee sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -sv -f compile.f --top-module procTb

clean:
	rm -rf obj_dir sim.log

//--- bench/procTb.sv
////////////////////////////////////////////////////////////
// Testbench for the five-stage core
// Loads a program, serves Wishbone with random wait states
// and checks bus transfers and flags against a reference
////////////////////////////////////////////////////////////
module procTb import isaPkg::*, pipePkg::*; ();

   localparam int imemAddrBits = 8;
   localparam int resetCycles  = 16;
   localparam int progLen      = 35;
   localparam logic [31:0] seed = 32'hb106_f6bd;
   localparam int watchdogCycles = 2 * (resetCycles + progLen + 40 * progLen * 4);

   logic                    clk;
   logic                    rstN;
   logic                    run;
   logic                    progWe;
   logic [imemAddrBits-1:0] progAddr;
   logic [15:0]             progData;
   wbReqT                   wbReq;
   logic [15:0]             wbDatI;
   logic                    wbAck;
   logic                    halted;
   logic                    err;

   logic [15:0] prog [progLen];
   logic [15:0] modelMem [256];
   logic [15:0] refMem [256];
   wbReqT       expQ [$];
   logic        expErr;
   logic [31:0] rngState;
   logic        pending;
   int          waitLeft;
   int          transfers;

   procTop #(.imemAddrBits(imemAddrBits)) procTop_inst (
      .clk(clk), .rstN(rstN), .run(run),
      .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .wbReq(wbReq), .wbDatI(wbDatI), .wbAck(wbAck),
      .halted(halted), .err(err));

   always #5 clk = ~clk;

   function automatic logic [31:0] nextRand();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   task automatic reportFailure(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic checkBus(input wbReqT got, input wbReqT exp);
      if (got.we !== exp.we || got.adr !== exp.adr || (exp.we && got.dat !== exp.dat)) begin
         reportFailure($sformatf(
            "Mismatch at %0t: transfer %0d got we=%b adr=%h dat=%h, want we=%b adr=%h dat=%h",
            $time, transfers, got.we, got.adr, got.dat, exp.we, exp.adr, exp.dat));
      end
   endtask

   task automatic checkFlags(input logic gotHalted, input logic gotErr, input logic wantErr);
      if (gotHalted !== 1'b1 || gotErr !== wantErr) begin
         reportFailure($sformatf("Mismatch at %0t: halted=%b err=%b, expected halted=1 err=%b",
            $time, gotHalted, gotErr, wantErr));
      end
   endtask

   task automatic checkWord(input int addr, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         reportFailure($sformatf("Mismatch at %0t: memory[%0d] is %h, expected %h",
            $time, addr, got, exp));
      end
   endtask

   function automatic logic [15:0] encR(opcodeT op, int a, int b, int c);
      return {op, 3'(a), 3'(b), 3'(c), 3'b000};
   endfunction

   function automatic logic [15:0] encI(opcodeT op, int a, int b, int imm);
      return {op, 3'(a), 3'(b), 6'(imm)};
   endfunction

   // ALU mix, dependent chains, loads, a counted loop and branches
   task automatic buildProgram(input logic illegalEnd);
      prog[0]  = encI(OP_ADDI, 1, 0, 5);
      prog[1]  = encI(OP_ADDI, 2, 0, -3);
      prog[2]  = encR(OP_ADD, 3, 1, 2);
      prog[3]  = encR(OP_SUB, 4, 1, 2);
      prog[4]  = encR(OP_AND, 5, 3, 4);
      prog[5]  = encR(OP_XOR, 6, 4, 2);
      prog[6]  = encI(OP_ST, 3, 0, 0);
      prog[7]  = encI(OP_ST, 4, 0, 1);
      prog[8]  = encI(OP_ST, 5, 0, 2);
      prog[9]  = encI(OP_ST, 6, 0, 3);
      prog[10] = encI(OP_LD, 7, 0, 10);
      prog[11] = encI(OP_ADDI, 7, 7, 1);
      prog[12] = encI(OP_ST, 7, 0, 4);
      prog[13] = encI(OP_LD, 3, 1, 20);
      prog[14] = encR(OP_XOR, 3, 3, 7);
      prog[15] = encI(OP_ST, 3, 1, 6);
      prog[16] = encI(OP_ADDI, 2, 0, 3);
      prog[17] = encI(OP_ADDI, 4, 0, 30);
      // Loop body runs three passes
      prog[18] = encI(OP_LD, 5, 4, 0);
      prog[19] = encR(OP_ADD, 6, 5, 2);
      prog[20] = encI(OP_ST, 6, 4, 8);
      prog[21] = encI(OP_ADDI, 4, 4, 1);
      prog[22] = encI(OP_ADDI, 2, 2, -1);
      prog[23] = encI(OP_BEQZ, 2, 0, 1);
      prog[24] = encI(OP_BEQZ, 0, 0, -7);
      prog[25] = encI(OP_ST, 2, 0, 5);
      prog[26] = encI(OP_BEQZ, 1, 0, 2);
      prog[27] = encI(OP_ADDI, 1, 1, 7);
      prog[28] = encI(OP_ST, 1, 0, 6);
      prog[29] = encI(OP_BEQZ, 0, 0, 1);
      prog[30] = encI(OP_ST, 1, 0, 7);
      prog[31] = encI(OP_ST, 4, 0, 8);
      prog[32] = encI(OP_NOP, 0, 0, 0);
      prog[33] = illegalEnd ? 16'hF000 : encI(OP_HALT, 0, 0, 0);
      prog[34] = encI(OP_ST, 1, 0, 9);
   endtask

   // Executes the program one instruction at a time on refMem
   function automatic void refRun();
      logic [15:0] r [8];
      logic [15:0] instr;
      logic [15:0] imm;
      logic [15:0] addr;
      logic [2:0]  a;
      logic [2:0]  b;
      logic [2:0]  c;
      int          pc;
      wbReqT       t;
      for (int i = 0; i < 8; i++) begin
         r[i] = '0;
      end
      pc = 0;
      expErr = 1'b0;
      for (int step = 0; step < 10000; step++) begin
         instr = prog[pc % progLen];
         a = instr[11:9];
         b = instr[8:6];
         c = instr[5:3];
         imm = {{10{instr[5]}}, instr[5:0]};
         addr = r[b] + imm;
         pc = pc + 1;
         t = '0;
         t.cyc = 1'b1;
         t.stb = 1'b1;
         t.adr = addr;
         case (opcodeT'(instr[15:12]))
            OP_HALT: return;
            OP_NOP: ;
            OP_ADD: r[a] = r[b] + r[c];
            OP_SUB: r[a] = r[b] - r[c];
            OP_AND: r[a] = r[b] & r[c];
            OP_XOR: r[a] = r[b] ^ r[c];
            OP_ADDI: r[a] = addr;
            OP_LD: begin
               expQ.push_back(t);
               r[a] = refMem[addr[7:0]];
            end
            OP_ST: begin
               t.we  = 1'b1;
               t.dat = r[a];
               expQ.push_back(t);
               refMem[addr[7:0]] = r[a];
            end
            OP_BEQZ: if (r[a] == 16'd0) pc = pc + int'($signed(imm));
            default: begin
               expErr = 1'b1;
               return;
            end
         endcase
      end
   endfunction

   // Wishbone slave with 0 to 3 wait states per transfer
   always @(posedge clk) begin
      #1;
      if (!rstN || wbAck) begin
         wbAck   = 1'b0;
         pending = 1'b0;
      end else if (wbReq.cyc && wbReq.stb) begin
         if (!pending) begin
            pending  = 1'b1;
            waitLeft = nextRand() % 4;
         end
         if (waitLeft == 0) begin
            wbAck = 1'b1;
            if (wbReq.we) begin
               modelMem[wbReq.adr[7:0]] = wbReq.dat;
            end else begin
               wbDatI = modelMem[wbReq.adr[7:0]];
            end
         end else begin
            waitLeft--;
         end
      end
   end

   // Each acknowledged transfer against the next expected one
   always @(negedge clk) begin
      if (rstN && wbReq.cyc && wbAck) begin
         if (expQ.size() == 0) begin
            reportFailure($sformatf("Unexpected bus transfer at %0t to address %h",
               $time, wbReq.adr));
         end else begin
            checkBus(wbReq, expQ.pop_front());
            transfers++;
         end
      end
   end

   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         @(posedge clk);
         #1;
         progWe   = 1'b1;
         progAddr = imemAddrBits'(i);
         progData = prog[i];
      end
      @(posedge clk);
      #1;
      progWe = 1'b0;
   endtask

   task automatic applyReset();
      repeat (resetCycles) @(posedge clk);
      #1;
      rstN = 1'b1;
   endtask

   task automatic runProgram(input logic illegalEnd);
      @(posedge clk);
      #1;
      rstN = 1'b0;
      run  = 1'b0;
      buildProgram(illegalEnd);
      rngState = seed;
      for (int i = 0; i < 256; i++) begin
         modelMem[i] = 16'(nextRand());
         refMem[i]   = modelMem[i];
      end
      expQ.delete();
      transfers = 0;
      refRun();
      fork
         applyReset();
         loadProgram();
      join
      run = 1'b1;
      while (halted !== 1'b1) begin
         @(negedge clk);
      end
      checkFlags(halted, err, expErr);
      // Flags stay set and nothing more reaches the bus
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         checkFlags(halted, err, expErr);
      end
      if (expQ.size() != 0) begin
         reportFailure($sformatf("%0d expected bus transfers never happened", expQ.size()));
      end
      for (int i = 0; i < 256; i++) begin
         checkWord(i, modelMem[i], refMem[i]);
      end
   endtask

   initial begin
      clk      = 1'b0;
      rstN     = 1'b0;
      run      = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      wbDatI   = '0;
      wbAck    = 1'b0;
      pending  = 1'b0;
      waitLeft = 0;
      runProgram(1'b0);
      runProgram(1'b1);
      if (expQ.size() == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         reportFailure("Transfers left over at the end of the run");
      end
   end

   initial begin
      repeat (watchdogCycles) @(posedge clk);
      reportFailure("Watchdog timeout, the core never halted");
   end

endmodule

//--- bench/procBus_properties.sv
////////////////////////////////////////////////////////////
// Wishbone and freeze assertions for the memory stage
////////////////////////////////////////////////////////////
module procBus_properties import pipePkg::*; (
   input logic  clk,
   input logic  rstN,
   input wbReqT wbReq,
   input logic  wbAck,
   input logic  memWait
);

   stbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN)
      wbReq.stb |-> wbReq.cyc)
      else $error("stb high without cyc");

   // Request must not change while waiting for ack
   reqStable: assert property (@(posedge clk) disable iff (!rstN)
      (wbReq.cyc && !wbAck) |=> (wbReq.cyc && $stable(wbReq)))
      else $error("Wishbone request changed before ack");

   waitNeedsCyc: assert property (@(posedge clk) disable iff (!rstN)
      !wbReq.cyc |-> !memWait)
      else $error("memWait high with no bus cycle");

endmodule

bind memStage procBus_properties busProps (
   .clk(clk), .rstN(rstN), .wbReq(wbReq), .wbAck(wbAck), .memWait(memWait));

//--- verilog/procTop.sv
////////////////////////////////////////////////////////////
// Five-stage 16-bit pipelined core
// Pipeline registers, hold and bubble control, writeback,
// halt and error flags
////////////////////////////////////////////////////////////
module procTop import pipePkg::*; #(
   parameter int imemAddrBits = 8
) (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic                    run,
   input  logic                    progWe,
   input  logic [imemAddrBits-1:0] progAddr,
   input  logic [15:0]             progData,
   output wbReqT                   wbReq,
   input  logic [15:0]             wbDatI,
   input  logic                    wbAck,
   output logic                    halted,
   output logic                    err
);

   fdRegT       fdNext, fd;
   deRegT       deNext, de;
   emRegT       emNext, em;
   mwRegT       mwNext, mw;
   logic        stall, memWait, redirect, stop, fetchStopped;
   logic        branchTaken, haltSeen;
   logic [15:0] branchTarget;
   logic [2:0]  rdAddrA, rdAddrB, rdAddrC;
   logic [15:0] rdDataA, rdDataB, rdDataC;

   // Branch only acts when decode really moves on
   assign redirect = branchTaken & ~stall & ~memWait;
   assign stop     = haltSeen | fetchStopped;

   fetchStage #(.imemAddrBits(imemAddrBits)) fetch (
      .clk(clk), .rstN(rstN), .run(run),
      .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .hold(memWait | stall), .squash(redirect), .redirect(redirect),
      .redirectPc(branchTarget), .stop(stop), .fdNext(fdNext));

   decodeStage decode (
      .fd(fd), .rdDataA(rdDataA), .rdDataB(rdDataB), .rdDataC(rdDataC),
      .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdAddrC(rdAddrC),
      .deNext(deNext), .branchTaken(branchTaken),
      .branchTarget(branchTarget), .haltSeen(haltSeen));

   regFile regs (
      .clk(clk), .rstN(rstN),
      .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdAddrC(rdAddrC),
      .wrEn(mw.ctrl.regWrite), .wrAddr(mw.ctrl.dest), .wrData(mw.wbVal),
      .rdDataA(rdDataA), .rdDataB(rdDataB), .rdDataC(rdDataC));

   stallDetector hazard (
      .fd(fd), .deCtrl(de.ctrl), .emCtrl(em.ctrl), .stall(stall));

   executeStage execute (.de(de), .emNext(emNext));

   memStage mem (
      .clk(clk), .rstN(rstN), .em(em), .wbDatI(wbDatI), .wbAck(wbAck),
      .wbReq(wbReq), .memWait(memWait), .mwNext(mwNext));

   // Memory wait freezes everything, a hazard only the front end
   always_ff @(posedge clk) begin
      if (!rstN) begin
         fd <= fdBubble;
         de <= deBubble;
         em <= emBubble;
         mw <= mwBubble;
      end else begin
         if (!memWait) begin
            if (!stall) begin
               fd <= fdNext;
            end
            de <= stall ? deBubble : deNext;
            em <= emNext;
         end
         mw <= memWait ? mwBubble : mwNext;
      end
   end

   // Sticky flags, fetch never restarts after a halt
   always_ff @(posedge clk) begin
      if (!rstN) begin
         fetchStopped <= 1'b0;
         halted       <= 1'b0;
         err          <= 1'b0;
      end else begin
         if (haltSeen) begin
            fetchStopped <= 1'b1;
         end
         if (mw.ctrl.isHalt) begin
            halted <= 1'b1;
            err    <= err | mw.ctrl.isIllegal;
         end
      end
   end

endmodule

//--- verilog/memStage.sv
////////////////////////////////////////////////////////////
// Memory stage
// Wishbone classic master, one transfer per LD or ST,
// freezes the pipeline until ack
////////////////////////////////////////////////////////////
module memStage import pipePkg::*; (
   input  logic        clk,
   input  logic        rstN,
   input  emRegT       em,
   input  logic [15:0] wbDatI,
   input  logic        wbAck,
   output wbReqT       wbReq,
   output logic        memWait,
   output mwRegT       mwNext
);

   typedef enum logic {
      MEM_IDLE,
      MEM_BUSY
   } memStateT;

   memStateT    state;
   logic        memOp;
   logic        start;
   logic        done;
   logic [15:0] rdData;

   assign memOp = em.ctrl.memRead | em.ctrl.memWrite;
   // done blocks a second transfer while em still holds the finished op
   assign start = (state == MEM_IDLE) && memOp && !done;

   // Request fields come from em, which holds during the freeze
   always_comb begin
      wbReq.cyc = start || (state == MEM_BUSY);
      wbReq.stb = wbReq.cyc;
      wbReq.we  = em.ctrl.memWrite;
      wbReq.adr = em.aluResult;
      wbReq.dat = em.storeData;
   end

   assign memWait = wbReq.cyc;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= MEM_IDLE;
         done  <= 1'b0;
      end else begin
         done <= wbReq.cyc & wbAck;
         case (state)
            MEM_IDLE: if (start && !wbAck) state <= MEM_BUSY;
            MEM_BUSY: if (wbAck) state <= MEM_IDLE;
         endcase
      end
   end

   // Read data sampled in the ack cycle
   always_ff @(posedge clk) begin
      if (wbReq.cyc && wbAck && !wbReq.we) begin
         rdData <= wbDatI;
      end
   end

   always_comb begin
      mwNext.ctrl  = em.ctrl;
      mwNext.wbVal = em.ctrl.memRead ? rdData : em.aluResult;
   end

endmodule

//--- verilog/executeStage.sv
////////////////////////////////////////////////////////////
// Execute stage
// ALU, also forms the LD and ST address
////////////////////////////////////////////////////////////
module executeStage import isaPkg::*, pipePkg::*; (
   input  deRegT de,
   output emRegT emNext
);

   always_comb begin
      emNext.ctrl      = de.ctrl;
      emNext.storeData = de.storeData;
      case (de.ctrl.aluOp)
         // Base plus offset for memory ops
         ALU_ADD: emNext.aluResult = de.opA + de.opB;
         ALU_SUB: emNext.aluResult = de.opA - de.opB;
         ALU_AND: emNext.aluResult = de.opA & de.opB;
         ALU_XOR: emNext.aluResult = de.opA ^ de.opB;
      endcase
   end

endmodule

//--- verilog/stallDetector.sv
////////////////////////////////////////////////////////////
// Read-after-write hazard check for the decode instruction
// against the writers in execute and memory
////////////////////////////////////////////////////////////
module stallDetector import isaPkg::*, pipePkg::*; (
   input  fdRegT fd,
   input  ctrlT  deCtrl,
   input  ctrlT  emCtrl,
   output logic  stall
);

   opcodeT     op;
   logic       isRType;
   logic       readsA;
   logic       readsB;
   logic       readsC;
   logic [2:0] srcA;
   logic [2:0] srcB;
   logic [2:0] srcC;

   function automatic logic pending(ctrlT de, ctrlT em, logic [2:0] src);
      return (de.regWrite && de.dest == src) || (em.regWrite && em.dest == src);
   endfunction

   assign op   = opcodeT'(fd.instr[opMsb:opLsb]);
   assign srcA = fd.instr[fieldAMsb:fieldALsb];
   assign srcB = fd.instr[fieldBMsb:fieldBLsb];
   assign srcC = fd.instr[fieldCMsb:fieldCLsb];

   // Which fields this opcode actually reads
   assign isRType = (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) || (op == OP_XOR);
   assign readsA  = (op == OP_ST) || (op == OP_BEQZ);
   assign readsB  = isRType || (op == OP_ADDI) || (op == OP_LD) || (op == OP_ST);
   assign readsC  = isRType;

   assign stall = fd.valid && ((readsA && pending(deCtrl, emCtrl, srcA)) ||
                               (readsB && pending(deCtrl, emCtrl, srcB)) ||
                               (readsC && pending(deCtrl, emCtrl, srcC)));

endmodule

//--- verilog/regFile.sv
////////////////////////////////////////////////////////////
// Register file, eight 16-bit entries
// Three read ports with same-cycle write bypass
////////////////////////////////////////////////////////////
module regFile (
   input  logic        clk,
   input  logic        rstN,
   input  logic [2:0]  rdAddrA,
   input  logic [2:0]  rdAddrB,
   input  logic [2:0]  rdAddrC,
   input  logic        wrEn,
   input  logic [2:0]  wrAddr,
   input  logic [15:0] wrData,
   output logic [15:0] rdDataA,
   output logic [15:0] rdDataB,
   output logic [15:0] rdDataC
);

   logic [15:0] regs [8];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Writeback value goes straight to a matching read
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];
   assign rdDataC = (wrEn && wrAddr == rdAddrC) ? wrData : regs[rdAddrC];

endmodule

//--- verilog/decodeStage.sv
////////////////////////////////////////////////////////////
// Decode stage
// Control decode, immediate extension, operand select and
// BEQZ resolution
////////////////////////////////////////////////////////////
module decodeStage import isaPkg::*, pipePkg::*; (
   input  fdRegT       fd,
   input  logic [15:0] rdDataA,
   input  logic [15:0] rdDataB,
   input  logic [15:0] rdDataC,
   output logic [2:0]  rdAddrA,
   output logic [2:0]  rdAddrB,
   output logic [2:0]  rdAddrC,
   output deRegT       deNext,
   output logic        branchTaken,
   output logic [15:0] branchTarget,
   output logic        haltSeen
);

   opcodeT      op;
   logic [15:0] imm;
   ctrlT        ctrl;

   assign op      = opcodeT'(fd.instr[opMsb:opLsb]);
   assign rdAddrA = fd.instr[fieldAMsb:fieldALsb];
   assign rdAddrB = fd.instr[fieldBMsb:fieldBLsb];
   assign rdAddrC = fd.instr[fieldCMsb:fieldCLsb];
   assign imm     = {{(15 - immMsb){fd.instr[immMsb]}}, fd.instr[immMsb:immLsb]};

   always_comb begin
      ctrl      = '0;
      ctrl.dest = rdAddrA;
      case (op)
         OP_NOP:  ctrl.regWrite = 1'b0;
         OP_ADD:  ctrl.regWrite = 1'b1;
         OP_SUB: begin
            ctrl.aluOp    = ALU_SUB;
            ctrl.regWrite = 1'b1;
         end
         OP_AND: begin
            ctrl.aluOp    = ALU_AND;
            ctrl.regWrite = 1'b1;
         end
         OP_XOR: begin
            ctrl.aluOp    = ALU_XOR;
            ctrl.regWrite = 1'b1;
         end
         OP_ADDI: begin
            ctrl.useImm   = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_LD: begin
            ctrl.useImm   = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         OP_ST: begin
            ctrl.useImm   = 1'b1;
            ctrl.memWrite = 1'b1;
         end
         OP_BEQZ: ctrl.regWrite = 1'b0;
         OP_HALT: ctrl.isHalt   = 1'b1;
         // Unknown opcode stops the core like HALT
         default: begin
            ctrl.isHalt    = 1'b1;
            ctrl.isIllegal = 1'b1;
         end
      endcase
      if (!fd.valid) begin
         ctrl = '0;
      end
   end

   always_comb begin
      deNext.ctrl      = ctrl;
      deNext.opA       = rdDataB;
      deNext.opB       = ctrl.useImm ? imm : rdDataC;
      deNext.storeData = rdDataA;
   end

   // Branch target is relative to the next instruction
   assign branchTaken  = fd.valid && (op == OP_BEQZ) && (rdDataA == 16'd0);
   assign branchTarget = fd.pcPlusOne + imm;
   assign haltSeen     = ctrl.isHalt;

endmodule

//--- verilog/fetchStage.sv
////////////////////////////////////////////////////////////
// Fetch stage
// Program counter, instruction memory with its load port
// and the branch redirect from decode
////////////////////////////////////////////////////////////
module fetchStage import pipePkg::*; #(
   parameter int imemAddrBits = 8
) (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic                    run,
   input  logic                    progWe,
   input  logic [imemAddrBits-1:0] progAddr,
   input  logic [15:0]             progData,
   input  logic                    hold,
   input  logic                    squash,
   input  logic                    redirect,
   input  logic [15:0]             redirectPc,
   input  logic                    stop,
   output fdRegT                   fdNext
);

   logic [15:0] imem [2**imemAddrBits];
   logic [15:0] pc;

   // Program load port, usable at any time
   always_ff @(posedge clk) begin
      if (progWe) begin
         imem[progAddr] <= progData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (!stop && !hold) begin
         if (redirect) begin
            pc <= redirectPc;
         end else if (run) begin
            pc <= pc + 16'd1;
         end
      end
   end

   // Upper PC bits do not reach the memory
   always_comb begin
      fdNext.instr     = imem[pc[imemAddrBits-1:0]];
      fdNext.pcPlusOne = pc + 16'd1;
      fdNext.valid     = run & ~squash & ~stop;
   end

endmodule

//--- verilog/pipePkg.sv
////////////////////////////////////////////////////////////
// Pipeline register layouts and the Wishbone request
////////////////////////////////////////////////////////////
package pipePkg;
   import isaPkg::*;

   // Fetch/decode
   typedef struct packed {
      logic [15:0] instr;
      logic [15:0] pcPlusOne;
      logic        valid;
   } fdRegT;

   // Decode/execute
   typedef struct packed {
      ctrlT        ctrl;
      logic [15:0] opA;
      logic [15:0] opB;
      logic [15:0] storeData;
   } deRegT;

   // Execute/memory
   typedef struct packed {
      ctrlT        ctrl;
      logic [15:0] aluResult;
      logic [15:0] storeData;
   } emRegT;

   // Memory/writeback
   typedef struct packed {
      ctrlT        ctrl;
      logic [15:0] wbVal;
   } mwRegT;

   // Wishbone classic master request
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;
      logic [15:0] dat;
   } wbReqT;

   localparam fdRegT fdBubble = '0;
   localparam deRegT deBubble = '0;
   localparam emRegT emBubble = '0;
   localparam mwRegT mwBubble = '0;

endpackage

//--- verilog/isaPkg.sv
////////////////////////////////////////////////////////////
// Instruction set of the 16-bit pipelined core
// Opcodes, field layout, ALU ops and decoded control bits
////////////////////////////////////////////////////////////
package isaPkg;

   // Major opcode in bits 15:12, anything not listed is illegal
   typedef enum logic [3:0] {
      OP_HALT = 4'h0,
      OP_NOP  = 4'h1,
      OP_ADD  = 4'h2,
      OP_SUB  = 4'h3,
      OP_AND  = 4'h4,
      OP_XOR  = 4'h5,
      OP_ADDI = 4'h6,
      OP_LD   = 4'h7,
      OP_ST   = 4'h8,
      OP_BEQZ = 4'h9
   } opcodeT;

   // Instruction field positions
   localparam int opMsb     = 15;
   localparam int opLsb     = 12;
   localparam int fieldAMsb = 11;
   localparam int fieldALsb = 9;
   localparam int fieldBMsb = 8;
   localparam int fieldBLsb = 6;
   localparam int fieldCMsb = 5;
   localparam int fieldCLsb = 3;
   localparam int immMsb    = 5;
   localparam int immLsb    = 0;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR
   } aluOpT;

   // All zero is a bubble
   typedef struct packed {
      aluOpT      aluOp;
      logic       useImm;
      logic       memRead;
      logic       memWrite;
      logic       regWrite;
      logic [2:0] dest;
      logic       isHalt;
      logic       isIllegal;
   } ctrlT;

endpackage
